/* list.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_cfg.sv
verilog/pre_if_stage.sv
verilog/if_stage.sv
verilog/inst_rom.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_cfg.sv
      - verilog/pre_if_stage.sv
      - verilog/if_stage.sv
      - verilog/inst_rom.sv
      - verilog/fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/fetch_tb.sv

/* testbench/fetch_tb.sv */
`include "fetch_defines.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    // 256 rom words plus ~200 entries at 9 cycles worst case, with margin
    localparam int  CYCLE_LIMIT  = 5000;
    localparam int  SEQ_LEN      = 24;
    localparam pc_t BR_TARGET    = 32'hbfc0_0300;
    localparam pc_t BAD_TARGET   = 32'hbfc0_0102;
    localparam pc_t FLUSH_VECTOR = 32'hbfc0_0200;

    logic       clk;
    logic       reset;
    br_bus_t    br_bus;
    logic       fs_bd;
    logic       flush;
    logic       ds_allowin;
    logic       fs_to_ds_valid;
    fs_to_ds_t  fs_to_ds_bus;
    logic       cfg_we;
    cfg_sel_e   cfg_sel;
    pc_t        cfg_wdata;
    pc_t        cfg_rdata;
    logic       load_en;
    rom_index_t load_addr;
    inst_t      load_data;

    // reference state
    inst_t       rom_copy [0:(1 << `ROM_ADDR_W) - 1];
    pc_t         exp_pc;
    logic        exp_bd;
    fs_to_ds_t   entry_q [$];
    int          cycle_cnt;
    int unsigned seed_dummy;

    // monitor state
    logic      monitor_on;
    logic      stalled;
    fs_to_ds_t held_bus;

    fetch_top UUT (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .fs_bd          (fs_bd),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .cfg_we         (cfg_we),
        .cfg_sel        (cfg_sel),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cfg(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // cycle limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, tests not finished after %0d cycles", cycle_cnt);
            stop_run();
        end
    end

    // decode side monitor, sampled mid-cycle
    // entries in a flush cycle are thrown away by decode
    always @(negedge clk) begin
        if (monitor_on && !reset) begin
            if (stalled && !fs_to_ds_valid) begin
                $display("entry vanished at %0t while decode was stalled", $time);
                stop_run();
            end else if (stalled) begin
                check_pc("held fs_to_ds_bus.pc", fs_to_ds_bus.pc, held_bus.pc);
                check_inst("held fs_to_ds_bus.inst", fs_to_ds_bus.inst, held_bus.inst);
                check_exc("held fs_to_ds_bus.exc_code", fs_to_ds_bus.exc_code,
                          held_bus.exc_code);
                check_flag("held fs_to_ds_bus.bd", fs_to_ds_bus.bd, held_bus.bd);
            end
            if (fs_to_ds_valid && ds_allowin && !flush) begin
                entry_q.push_back(fs_to_ds_bus);
            end
            stalled  = fs_to_ds_valid && !ds_allowin && !flush;
            held_bus = fs_to_ds_bus;
        end else begin
            stalled = 1'b0;
        end
    end

    // next entry taken by decode, returns on a rising edge
    task automatic next_entry(output fs_to_ds_t e);
        while (entry_q.size() == 0) begin
            @(posedge clk);
        end
        e = entry_q.pop_front();
    endtask

    // reference model: word at pc[9:2], AdEL on a misaligned pc
    task automatic check_entry(input fs_to_ds_t e);
        logic      aligned;
        inst_t     exp_inst;
        exc_code_t exp_exc;
        aligned  = exp_pc[1:0] == 2'b00;
        exp_inst = aligned ? rom_copy[exp_pc[`ROM_ADDR_W+1:2]] : '0;
        exp_exc  = aligned ? `EXC_NONE : `EXC_ADEL;
        check_pc("fs_to_ds_bus.pc", e.pc, exp_pc);
        check_inst("fs_to_ds_bus.inst", e.inst, exp_inst);
        check_exc("fs_to_ds_bus.exc_code", e.exc_code, exp_exc);
        check_flag("fs_to_ds_bus.ex", e.ex, !aligned);
        check_flag("fs_to_ds_bus.bd", e.bd, exp_bd);
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic expect_entries(input int n);
        fs_to_ds_t e;
        for (int i = 0; i < n; i++) begin
            next_entry(e);
            check_entry(e);
        end
    endtask

    task automatic load_rom();
        for (int i = 0; i < (1 << `ROM_ADDR_W); i++) begin
            @(posedge clk);
            rom_copy[i] = $urandom();
            load_en   <= 1'b1;
            load_addr <= rom_index_t'(i);
            load_data <= rom_copy[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("fs_to_ds_valid", fs_to_ds_valid, 1'b0);
        @(posedge clk);
        reset <= 1'b0;
        monitor_on = 1'b1;
    endtask

    task automatic cfg_write(input cfg_sel_e sel, input pc_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    // readback is combinational, look mid-cycle
    task automatic cfg_readback(input cfg_sel_e sel, input pc_t exp);
        @(posedge clk);
        cfg_sel <= sel;
        @(negedge clk);
        check_cfg("cfg_rdata", cfg_rdata, exp);
    endtask

    // one-cycle flush, earlier entries dropped from the queue
    // decode stalls in that cycle, so only the flush can clear valid
    task automatic flush_fetch();
        @(posedge clk);
        flush      <= 1'b1;
        ds_allowin <= 1'b0;
        @(posedge clk);
        flush      <= 1'b0;
        ds_allowin <= 1'b1;
        entry_q.delete();
        @(negedge clk);
        check_flag("fs_to_ds_valid after flush", fs_to_ds_valid, 1'b0);
    endtask

    // taken pulse, then at most one delay-slot pc before the target
    task automatic branch_to(input pc_t target);
        fs_to_ds_t e;
        @(posedge clk);
        while (entry_q.size() > 0) begin
            e = entry_q.pop_front();
            check_entry(e);
        end
        br_bus.taken  <= 1'b1;
        br_bus.target <= target;
        @(posedge clk);
        br_bus.taken <= 1'b0;
        next_entry(e);
        if (e.pc !== target) begin
            // delay slot, still on the old path
            check_entry(e);
            next_entry(e);
        end
        exp_pc = target;
        check_entry(e);
    endtask

    task automatic test_sequential();
        fs_to_ds_t e;
        exp_pc = `RESET_PC;
        for (int i = 0; i < SEQ_LEN; i++) begin
            next_entry(e);
            exp_bd = (i >= 8) && (i < 16);
            check_entry(e);
            // next go is at least one cycle away
            fs_bd <= (i + 1 >= 8) && (i + 1 < 16);
        end
        exp_bd = 1'b0;
    endtask

    task automatic test_backpressure();
        bit bp_done;
        bp_done = 1'b0;
        fork
            begin
                while (!bp_done) begin
                    @(posedge clk);
                    ds_allowin <= $urandom_range(0, 99) < 55;
                end
            end
            begin
                expect_entries(40);
                bp_done = 1'b1;
            end
        join
        @(posedge clk);
        ds_allowin <= 1'b1;
    endtask

    // restart at the boot pc through the vector, same words expected
    task automatic rerun_boot(input pc_t wait_cnt);
        cfg_write(CFG_MEM_WAIT, wait_cnt);
        cfg_readback(CFG_MEM_WAIT, wait_cnt);
        flush_fetch();
        exp_pc = `RESET_PC;
        expect_entries(SEQ_LEN);
    endtask

    task automatic test_config();
        // still at reset values
        cfg_readback(CFG_EXC_VECTOR, `EXC_VECTOR_RESET);
        cfg_readback(CFG_MEM_WAIT, 32'd0);
        // low two bits of the vector are masked
        cfg_write(CFG_EXC_VECTOR, 32'h8000_0187);
        cfg_readback(CFG_EXC_VECTOR, 32'h8000_0184);
        cfg_write(CFG_MEM_WAIT, 32'hffff_fffd);
        cfg_readback(CFG_MEM_WAIT, 32'd5);
        cfg_write(CFG_EXC_VECTOR, `RESET_PC);
        rerun_boot(32'd3);
        rerun_boot(32'd7);
    endtask

    task automatic test_branch();
        expect_entries(2);
        branch_to(BR_TARGET);
        expect_entries(6);
    endtask

    // flush lands while the request after a fresh entry is in memory
    task automatic test_flush();
        fs_to_ds_t e;
        cfg_write(CFG_EXC_VECTOR, FLUSH_VECTOR);
        cfg_write(CFG_MEM_WAIT, 32'd5);
        entry_q.delete();
        next_entry(e);
        flush_fetch();
        exp_pc = FLUSH_VECTOR;
        expect_entries(4);
    endtask

    task automatic test_misaligned();
        expect_entries(1);
        branch_to(BAD_TARGET);
        flush_fetch();
        exp_pc = FLUSH_VECTOR;
        expect_entries(3);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b0;
        br_bus     = '0;
        fs_bd      = 1'b0;
        flush      = 1'b0;
        ds_allowin = 1'b1;
        cfg_we     = 1'b0;
        cfg_sel    = CFG_EXC_VECTOR;
        cfg_wdata  = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        cycle_cnt  = 0;
        monitor_on = 1'b0;
        stalled    = 1'b0;
        exp_bd     = 1'b0;
        // seed the generator once
        seed_dummy = $urandom(48);

        load_rom();
        apply_reset();

        test_sequential();
        test_backpressure();
        test_config();
        test_branch();
        test_flush();
        test_misaligned();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog/fetch_top.sv */
module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::br_bus_t    br_bus,
    input  logic                  fs_bd,
    input  logic                  flush,
    input  logic                  ds_allowin,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t  fs_to_ds_bus,
    input  logic                  cfg_we,
    input  fetch_pkg::cfg_sel_e   cfg_sel,
    input  fetch_pkg::pc_t        cfg_wdata,
    output fetch_pkg::pc_t        cfg_rdata,
    input  logic                  load_en,
    input  fetch_pkg::rom_index_t load_addr,
    input  fetch_pkg::inst_t      load_data
);
    import fetch_pkg::*;

    // cfg to fetch and memory
    pc_t       exc_vector;
    mem_wait_t mem_wait;

    // pre-if and if handshake
    ps_to_fs_t ps_to_fs;
    pc_t       fs_pc;
    logic      fs_allowin;

    // memory side
    logic      inst_req;
    pc_t       inst_addr;
    logic      inst_data_ok;
    inst_t     inst_rdata;

    fetch_cfg u_fetch_cfg (
        .clk        (clk),
        .reset      (reset),
        .cfg_we     (cfg_we),
        .cfg_sel    (cfg_sel),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .exc_vector (exc_vector),
        .mem_wait   (mem_wait)
    );

    pre_if_stage u_pre_if_stage (
        .clk          (clk),
        .reset        (reset),
        .fs_pc        (fs_pc),
        .fs_allowin   (fs_allowin),
        .br_bus       (br_bus),
        .flush        (flush),
        .exc_vector   (exc_vector),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_data_ok (inst_data_ok),
        .ps_to_fs     (ps_to_fs)
    );

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .ps_to_fs       (ps_to_fs),
        .inst_rdata     (inst_rdata),
        .fs_bd          (fs_bd),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .fs_allowin     (fs_allowin),
        .fs_pc          (fs_pc),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    inst_rom u_inst_rom (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .mem_wait     (mem_wait),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data)
    );

endmodule

/* verilog/inst_rom.sv */
`include "fetch_defines.svh"

module inst_rom (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_req,
    input  fetch_pkg::pc_t        inst_addr,
    input  fetch_pkg::mem_wait_t  mem_wait,
    output logic                  inst_data_ok,
    output fetch_pkg::inst_t      inst_rdata,
    input  logic                  load_en,
    input  fetch_pkg::rom_index_t load_addr,
    input  fetch_pkg::inst_t      load_data
);
    import fetch_pkg::*;

    inst_t      mem [0:(1 << `ROM_ADDR_W) - 1];
    rom_state_e state;
    rom_index_t req_index;
    rom_index_t rd_index;
    mem_wait_t  wait_cnt;
    logic       accept;
    logic       fire;

    // word index from byte address
    // idle reads straight from the request, wait uses the latched index
    assign rd_index = (state == ROM_IDLE) ? inst_addr[`ROM_ADDR_W+1:2] : req_index;

    assign accept = (state == ROM_IDLE) & inst_req;

    // last edge before data_ok goes high
    assign fire = (state == ROM_IDLE) ? (inst_req && mem_wait == '0)
                                      : (wait_cnt == mem_wait_t'(1));

    // load port, one word per clock, any time
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // response fsm
    // requests while waiting are ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ROM_IDLE;
            wait_cnt     <= '0;
            inst_data_ok <= 1'b0;
        end else begin
            inst_data_ok <= fire;
            case (state)
                ROM_IDLE: begin
                    if (inst_req && mem_wait != '0) begin
                        state    <= ROM_WAIT;
                        wait_cnt <= mem_wait;
                    end
                end
                ROM_WAIT: begin
                    wait_cnt <= wait_cnt - mem_wait_t'(1);
                    if (fire) begin
                        state <= ROM_IDLE;
                    end
                end
                default: begin
                    state <= ROM_IDLE;
                end
            endcase
        end
    end

    // index latch and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            req_index <= rd_index;
        end
        if (fire) begin
            inst_rdata <= mem[rd_index];
        end
    end

endmodule

/* verilog/if_stage.sv */
`include "fetch_defines.svh"

module if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::ps_to_fs_t ps_to_fs,
    input  fetch_pkg::inst_t     inst_rdata,
    input  logic                 fs_bd,
    input  logic                 flush,
    input  logic                 ds_allowin,
    output logic                 fs_allowin,
    output fetch_pkg::pc_t       fs_pc,
    output logic                 fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t fs_to_ds_bus
);
    import fetch_pkg::*;

    inst_t     slot_inst;
    logic      slot_bd;
    logic      go_aligned;
    logic      adel;
    exc_code_t exc_code;

    // slot can take a new entry when empty, drained, or flushed
    assign fs_allowin = ~fs_to_ds_valid | ds_allowin | flush;

    assign go_aligned = ps_to_fs.pc[1:0] == 2'b00;

    // valid flag
    // go refills even while decode takes the old entry
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_to_ds_valid <= 1'b0;
        end else if (flush) begin
            fs_to_ds_valid <= 1'b0;
        end else if (ps_to_fs.go) begin
            fs_to_ds_valid <= 1'b1;
        end else if (ds_allowin) begin
            fs_to_ds_valid <= 1'b0;
        end
    end

    // pc of the slot, also the base for the sequential path
    // starts one word early so that +4 lands on the boot pc
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= `RESET_PC - 32'd4;
        end else if (ps_to_fs.go) begin
            fs_pc <= ps_to_fs.pc;
        end
    end

    // instruction and delay-slot tag
    // bad pc never reached memory, so store zero
    always_ff @(posedge clk) begin
        if (ps_to_fs.go) begin
            slot_inst <= go_aligned ? inst_rdata : '0;
            slot_bd   <= fs_bd;
        end
    end

    // AdEL from the stored pc
    assign adel     = fs_pc[1:0] != 2'b00;
    assign exc_code = adel ? `EXC_ADEL : `EXC_NONE;

    // bus to decode
    assign fs_to_ds_bus.ex       = adel;
    assign fs_to_ds_bus.exc_code = exc_code;
    assign fs_to_ds_bus.bd       = slot_bd;
    assign fs_to_ds_bus.inst     = slot_inst;
    assign fs_to_ds_bus.pc       = fs_pc;

endmodule

/* verilog/pre_if_stage.sv */
module pre_if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::pc_t       fs_pc,
    input  logic                 fs_allowin,
    input  fetch_pkg::br_bus_t   br_bus,
    input  logic                 flush,
    input  fetch_pkg::pc_t       exc_vector,
    output logic                 inst_req,
    output fetch_pkg::pc_t       inst_addr,
    input  logic                 inst_data_ok,
    output fetch_pkg::ps_to_fs_t ps_to_fs
);
    import fetch_pkg::*;

    logic fetch_en;
    logic outstanding;
    logic cancel;
    logic flush_pend;
    logic br_pend;
    pc_t  br_target;
    pc_t  req_pc;
    pc_t  next_pc;
    logic issue;
    logic misaligned;
    logic resp_ok;

    // next pc, flush beats branch beats sequential
    always_comb begin
        if (flush || flush_pend) begin
            next_pc = exc_vector;
        end else if (br_bus.taken) begin
            next_pc = br_bus.target;
        end else if (br_pend) begin
            next_pc = br_target;
        end else begin
            next_pc = fs_pc + 32'd4;
        end
    end

    assign misaligned = next_pc[1:0] != 2'b00;

    // one slot of issue per cycle, only with nothing in memory
    assign issue     = fetch_en & fs_allowin & ~outstanding;
    assign inst_req  = issue & ~misaligned;
    assign inst_addr = next_pc;

    // response dropped if flushed before or on arrival
    assign resp_ok = inst_data_ok & outstanding & ~cancel & ~flush;

    // misaligned pc skips memory and goes straight to the slot
    assign ps_to_fs.go = resp_ok | (issue & misaligned);
    assign ps_to_fs.pc = inst_data_ok ? req_pc : next_pc;

    // hold off the first request by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // outstanding and cancel tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
            cancel      <= 1'b0;
        end else if (inst_req) begin
            outstanding <= 1'b1;
            cancel      <= 1'b0;
        end else if (inst_data_ok) begin
            outstanding <= 1'b0;
            cancel      <= 1'b0;
        end else if (flush && outstanding) begin
            cancel <= 1'b1;
        end
    end

    // redirects that could not be used this cycle
    // flush wipes any branch still waiting
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_pend <= 1'b0;
            br_pend    <= 1'b0;
        end else if (issue) begin
            flush_pend <= 1'b0;
            br_pend    <= 1'b0;
        end else if (flush) begin
            flush_pend <= 1'b1;
            br_pend    <= 1'b0;
        end else if (br_bus.taken) begin
            br_pend <= 1'b1;
        end
    end

    // payload, target and the pc sent to memory
    always_ff @(posedge clk) begin
        if (br_bus.taken && !issue) begin
            br_target <= br_bus.target;
        end
        if (inst_req) begin
            req_pc <= next_pc;
        end
    end

endmodule

/* verilog/fetch_cfg.sv */
`include "fetch_defines.svh"

module fetch_cfg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_we,
    input  fetch_pkg::cfg_sel_e  cfg_sel,
    input  fetch_pkg::pc_t       cfg_wdata,
    output fetch_pkg::pc_t       cfg_rdata,
    output fetch_pkg::pc_t       exc_vector,
    output fetch_pkg::mem_wait_t mem_wait
);
    import fetch_pkg::*;

    // write side
    // vector is word aligned, so low two bits never stored as ones
    always_ff @(posedge clk) begin
        if (reset) begin
            exc_vector <= `EXC_VECTOR_RESET;
        end else if (cfg_we && cfg_sel == CFG_EXC_VECTOR) begin
            exc_vector <= {cfg_wdata[31:2], 2'b00};
        end
    end

    // wait count keeps only its low bits
    // 0 means data back on the cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wait <= '0;
        end else if (cfg_we && cfg_sel == CFG_MEM_WAIT) begin
            mem_wait <= cfg_wdata[`WAIT_W-1:0];
        end
    end

    // readback, combinational from the select
    // wait count comes back zero extended
    always_comb begin
        case (cfg_sel)
            CFG_EXC_VECTOR: begin
                cfg_rdata = exc_vector;
            end
            CFG_MEM_WAIT: begin
                cfg_rdata = pc_t'(mem_wait);
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

/* verilog/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    // widths with a meaning
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] exc_code_t;
    typedef logic [`ROM_ADDR_W-1:0] rom_index_t;
    typedef logic [`WAIT_W-1:0] mem_wait_t;

    // config register select
    typedef enum logic {
        CFG_EXC_VECTOR = 1'b0,
        CFG_MEM_WAIT   = 1'b1
    } cfg_sel_e;

    // rom response fsm
    typedef enum logic {
        ROM_IDLE = 1'b0,
        ROM_WAIT = 1'b1
    } rom_state_e;

    // branch redirect from decode, taken is a one-cycle pulse
    typedef struct packed {
        logic taken;
        pc_t  target;
    } br_bus_t;

    // load command into the fetch slot
    typedef struct packed {
        logic go;
        pc_t  pc;
    } ps_to_fs_t;

    // entry handed to decode
    // same bit layout as the old flat bus, ex on bit 70 down to pc on 31:0
    typedef struct packed {
        logic      ex;
        exc_code_t exc_code;
        logic      bd;
        inst_t     inst;
        pc_t       pc;
    } fs_to_ds_t;

endpackage

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// boot rom entry, first pc fetched after reset
`define RESET_PC 32'hbfc00000

// exception entry on flush until software moves it
`define EXC_VECTOR_RESET 32'hbfc00380

// fetch address error, load or instruction fetch
`define EXC_ADEL 5'h04

// all ones means no exception in this slot
`define EXC_NONE 5'h1f

// rom word index width
// 8 bits gives 256 words, so address bits 9:2
`define ROM_ADDR_W 8

// wait-state counter width
// max 7 wait states per access
`define WAIT_W 3

`endif
